//--- design/poly_mem_pkg.sv
package poly_mem_pkg;

	localparam int buffer_size = 1024;
	localparam int coef_depth = 128;
	localparam int poly_count = 8;

	// one word address covers data, coefficients and degrees
	typedef logic [11:0] mem_addr_t;
	typedef logic [9:0] data_addr_t;
	typedef logic [15:0] mem_word_t;

	localparam mem_addr_t coef_base = 12'd1024;
	localparam mem_addr_t degree_base = 12'd1152;
	localparam mem_addr_t degree_end = 12'd1160;

	localparam int data_aw = $clog2(buffer_size);
	localparam int coef_aw = $clog2(coef_depth);
	localparam int degree_aw = $clog2(poly_count);

endpackage

//--- design/poly_eval_pkg.sv
package poly_eval_pkg;

	typedef logic [2:0] poly_sel_t;
	typedef logic [4:0] degree_t;
	typedef logic [4:0] point_count_t;
	typedef logic [31:0] result_t;

	// status word: {14'b0, degree used, polynomial, point address}
	typedef logic [31:0] status_t;

	localparam status_t status_idle = '1;
	localparam degree_t max_degree = 5'd15;

	typedef enum logic [2:0]
	{
		ev_idle,
		ev_deg_req,
		ev_deg_wait,
		ev_x_req,
		ev_x_wait,
		ev_coef_req,
		ev_coef_wait
	} eval_state_t;

	typedef enum logic [1:0]
	{
		b_idle,
		b_launch,
		b_wait,
		b_end
	} batch_state_t;

endpackage

//--- design/store_port_if.sv
`timescale 1ns/1ps

interface store_port_if;
	import poly_mem_pkg::*;

	logic req;
	logic we;
	mem_addr_t addr;
	mem_word_t wdata;
	mem_word_t rdata;
	logic gnt;

	// request fields stay steady until gnt is seen in the same cycle
	modport requester
	(
		output req, we, addr, wdata,
		input gnt, rdata
	);

	modport arbiter
	(
		input req, we, addr, wdata,
		output gnt, rdata
	);

endinterface

//--- design/store_arbiter.sv
`timescale 1ns/1ps

module store_arbiter
(
	input logic clk,
	input logic rst,
	store_port_if.arbiter host,
	store_port_if.arbiter eval,
	output logic mem_en,
	output logic mem_we,
	output poly_mem_pkg::mem_addr_t mem_addr,
	output poly_mem_pkg::mem_word_t mem_wdata,
	input poly_mem_pkg::mem_word_t mem_rdata
);

	logic host_rd_q;
	logic eval_rd_q;

	// the host always wins and the evaluator only gets idle host cycles
	assign host.gnt = host.req;
	assign eval.gnt = eval.req && !host.req;

	assign mem_en = host.req || eval.req;
	assign mem_we = host.req ? host.we : eval.we;
	assign mem_addr = host.req ? host.addr : eval.addr;
	assign mem_wdata = host.req ? host.wdata : eval.wdata;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			host_rd_q <= 1'b0;
			eval_rd_q <= 1'b0;
		end
		else
		begin
			host_rd_q <= host.gnt && !host.we;
			eval_rd_q <= eval.gnt && !eval.we;
		end
	end

	// read data goes back only to whoever issued the read last cycle
	assign host.rdata = host_rd_q ? mem_rdata : '0;
	assign eval.rdata = eval_rd_q ? mem_rdata : '0;

	// a waiting evaluator keeps its read steady until it is granted
	a_eval_holds: assert property (@(posedge clk) disable iff (!rst)
		(eval.req && !eval.gnt) |=> (eval.req && $stable(eval.addr)));

endmodule

//--- design/poly_store.sv
`timescale 1ns/1ps

module poly_store
(
	input logic clk,
	input logic rst,
	input logic en,
	input logic we,
	input poly_mem_pkg::mem_addr_t addr,
	input poly_mem_pkg::mem_word_t wdata,
	output poly_mem_pkg::mem_word_t rdata
);
	import poly_mem_pkg::*;

	mem_word_t data_mem [buffer_size];
	mem_word_t coef_mem [coef_depth];
	mem_word_t deg_mem [poly_count];

	logic in_data;
	logic in_coef;
	logic in_deg;
	mem_addr_t coef_off;
	mem_addr_t deg_off;

	// region decode, anything past the degree words is unmapped
	assign in_data = addr < coef_base;
	assign in_coef = (addr >= coef_base) && (addr < degree_base);
	assign in_deg = (addr >= degree_base) && (addr < degree_end);

	assign coef_off = addr - coef_base;
	assign deg_off = addr - degree_base;

	always_ff @(posedge clk)
	begin
		if (en && we)
		begin
			if (in_data)
				data_mem[addr[data_aw-1:0]] <= wdata;
			else if (in_coef)
				coef_mem[coef_off[coef_aw-1:0]] <= wdata;
			else if (in_deg)
				deg_mem[deg_off[degree_aw-1:0]] <= wdata;
		end
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			rdata <= '0;
		else if (en && !we)
		begin
			if (in_data)
				rdata <= data_mem[addr[data_aw-1:0]];
			else if (in_coef)
				rdata <= coef_mem[coef_off[coef_aw-1:0]];
			else if (in_deg)
				rdata <= deg_mem[deg_off[degree_aw-1:0]];
			else
				rdata <= '0;
		end
	end

endmodule

//--- design/host_port.sv
`timescale 1ns/1ps

module host_port
(
	input logic clk,
	input logic rst,
	input logic host_wr,
	input logic host_rd,
	input poly_mem_pkg::mem_addr_t host_addr,
	input poly_mem_pkg::mem_word_t host_wdata,
	output poly_mem_pkg::mem_word_t host_rdata,
	output logic host_rd_valid,
	store_port_if.requester bus
);
	import poly_mem_pkg::*;

	logic req_q;
	logic we_q;
	mem_addr_t addr_q;
	mem_word_t wdata_q;

	// a write strobe wins if both arrive together
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			req_q <= 1'b0;
			we_q <= 1'b0;
			host_rd_valid <= 1'b0;
		end
		else
		begin
			if (host_wr || host_rd)
			begin
				req_q <= 1'b1;
				we_q <= host_wr;
			end
			else if (bus.gnt)
				req_q <= 1'b0;
			host_rd_valid <= bus.req && bus.gnt && !bus.we;
		end
	end

	always_ff @(posedge clk)
	begin
		if (host_wr || host_rd)
		begin
			addr_q <= host_addr;
			wdata_q <= host_wdata;
		end
	end

	assign bus.req = req_q;
	assign bus.we = we_q;
	assign bus.addr = addr_q;
	assign bus.wdata = wdata_q;

	// store data lands together with host_rd_valid
	assign host_rdata = bus.rdata;

	a_no_strobe_pending: assert property (@(posedge clk) disable iff (!rst)
		bus.req |-> !(host_wr || host_rd));

endmodule

//--- design/poly_point_eval.sv
`timescale 1ns/1ps

module poly_point_eval
(
	input logic clk,
	input logic rst,
	input logic start_point,
	input poly_eval_pkg::poly_sel_t sel,
	input poly_mem_pkg::data_addr_t point_addr,
	store_port_if.requester bus,
	output logic done_point,
	output poly_eval_pkg::result_t result,
	output poly_eval_pkg::status_t status
);
	import poly_mem_pkg::*;
	import poly_eval_pkg::*;

	eval_state_t state;
	degree_t idx_q;
	poly_sel_t sel_q;
	data_addr_t addr_q;
	degree_t deg_q;
	mem_word_t x_q;
	result_t acc_q;
	result_t next_acc;
	degree_t deg_clip;
	mem_addr_t rd_addr;

	// one Horner step, wrapping at 32 bits
	assign next_acc = acc_q * result_t'(x_q) + result_t'(bus.rdata);

	assign deg_clip = (bus.rdata > mem_word_t'(max_degree)) ? max_degree
		: degree_t'(bus.rdata);

	always_comb
	begin
		case (state)
			ev_deg_req:
				rd_addr = degree_base + mem_addr_t'(sel_q);
			ev_x_req:
				rd_addr = mem_addr_t'(addr_q);
			default:
				rd_addr = coef_base + mem_addr_t'({sel_q, idx_q[3:0]});
		endcase
	end

	assign bus.req = (state == ev_deg_req) || (state == ev_x_req) || (state == ev_coef_req);
	assign bus.we = 1'b0;
	assign bus.addr = rd_addr;
	assign bus.wdata = '0;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= ev_idle;
			idx_q <= '0;
			done_point <= 1'b0;
			result <= '0;
			status <= status_idle;
		end
		else
		begin
			done_point <= 1'b0;
			case (state)
				ev_idle:
					if (start_point)
						state <= ev_deg_req;
				ev_deg_req:
					if (bus.gnt)
						state <= ev_deg_wait;
				ev_deg_wait:
				begin
					idx_q <= deg_clip;
					state <= ev_x_req;
				end
				ev_x_req:
					if (bus.gnt)
						state <= ev_x_wait;
				ev_x_wait:
					state <= ev_coef_req;
				ev_coef_req:
					if (bus.gnt)
						state <= ev_coef_wait;
				ev_coef_wait:
				begin
					// coefficient 0 was the last read of this point
					if (idx_q == '0)
					begin
						done_point <= 1'b1;
						result <= next_acc;
						status <= status_t'({deg_q, sel_q, addr_q});
						state <= ev_idle;
					end
					else
					begin
						idx_q <= idx_q - 1'b1;
						state <= ev_coef_req;
					end
				end
				default:
					state <= ev_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		case (state)
			ev_idle:
				if (start_point)
				begin
					sel_q <= sel;
					addr_q <= point_addr;
				end
			ev_deg_wait:
				deg_q <= deg_clip;
			ev_x_wait:
			begin
				x_q <= bus.rdata;
				acc_q <= '0;
			end
			ev_coef_wait:
				acc_q <= next_acc;
			default:
				acc_q <= acc_q;
		endcase
	end

endmodule

//--- design/poly_batch_ctrl.sv
`timescale 1ns/1ps

module poly_batch_ctrl
(
	input logic clk,
	input logic rst,
	input logic start,
	input poly_eval_pkg::poly_sel_t sel,
	input poly_eval_pkg::point_count_t count,
	input poly_mem_pkg::data_addr_t base_addr,
	output logic eval_start,
	output poly_eval_pkg::poly_sel_t eval_sel,
	output poly_mem_pkg::data_addr_t eval_addr,
	input logic eval_done,
	output logic done_batch
);
	import poly_mem_pkg::*;
	import poly_eval_pkg::*;

	batch_state_t state;
	point_count_t idx_q;
	point_count_t next_idx;
	point_count_t last_q;
	poly_sel_t sel_q;
	data_addr_t base_q;

	assign next_idx = idx_q + 1'b1;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= b_idle;
			idx_q <= '0;
		end
		else
		begin
			case (state)
				b_idle:
					if (start)
					begin
						idx_q <= '0;
						state <= b_launch;
					end
				b_launch:
					state <= b_wait;
				b_wait:
					if (eval_done)
					begin
						idx_q <= next_idx;
						if (next_idx == last_q)
							state <= b_end;
						else
							state <= b_launch;
					end
				b_end:
					state <= b_idle;
				default:
					state <= b_idle;
			endcase
		end
	end

	// a count of zero still runs one point
	always_ff @(posedge clk)
	begin
		if ((state == b_idle) && start)
		begin
			sel_q <= sel;
			base_q <= base_addr;
			last_q <= (count == '0) ? point_count_t'(1) : count;
		end
	end

	assign eval_start = (state == b_launch);
	assign eval_sel = sel_q;
	// the address wraps inside the data buffer by its width
	assign eval_addr = base_q + data_addr_t'(idx_q);
	assign done_batch = (state == b_end);

	// the evaluator only finishes a point that this controller is waiting for
	a_done_in_wait: assert property (@(posedge clk) disable iff (!rst)
		eval_done |-> (state == b_wait));

endmodule

//--- design/poly_eval_top.sv
`timescale 1ns/1ps

module poly_eval_top
(
	input logic clk,
	input logic rst,
	input logic host_wr,
	input logic host_rd,
	input poly_mem_pkg::mem_addr_t host_addr,
	input poly_mem_pkg::mem_word_t host_wdata,
	output poly_mem_pkg::mem_word_t host_rdata,
	output logic host_rd_valid,
	input logic start,
	input poly_eval_pkg::poly_sel_t sel,
	input poly_eval_pkg::point_count_t count,
	input poly_mem_pkg::data_addr_t base_addr,
	output logic done_point,
	output logic done_batch,
	output poly_eval_pkg::result_t result,
	output poly_eval_pkg::status_t status
);
	import poly_mem_pkg::*;
	import poly_eval_pkg::*;

	logic mem_en;
	logic mem_we;
	mem_addr_t mem_addr;
	mem_word_t mem_wdata;
	mem_word_t mem_rdata;
	logic eval_start;
	poly_sel_t eval_sel;
	data_addr_t eval_addr;

	store_port_if host_bus ();
	store_port_if eval_bus ();

	store_arbiter u_arbiter
	(
		.clk(clk), .rst(rst), .host(host_bus.arbiter), .eval(eval_bus.arbiter),
		.mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
	);

	poly_store u_store
	(
		.clk(clk), .rst(rst), .en(mem_en), .we(mem_we), .addr(mem_addr),
		.wdata(mem_wdata), .rdata(mem_rdata)
	);

	host_port u_host
	(
		.clk(clk), .rst(rst), .host_wr(host_wr), .host_rd(host_rd),
		.host_addr(host_addr), .host_wdata(host_wdata), .host_rdata(host_rdata),
		.host_rd_valid(host_rd_valid), .bus(host_bus.requester)
	);

	poly_point_eval u_point
	(
		.clk(clk), .rst(rst), .start_point(eval_start), .sel(eval_sel),
		.point_addr(eval_addr), .bus(eval_bus.requester), .done_point(done_point),
		.result(result), .status(status)
	);

	poly_batch_ctrl u_batch
	(
		.clk(clk), .rst(rst), .start(start), .sel(sel), .count(count),
		.base_addr(base_addr), .eval_start(eval_start), .eval_sel(eval_sel),
		.eval_addr(eval_addr), .eval_done(done_point), .done_batch(done_batch)
	);

endmodule

//--- dv/poly_eval_tb.sv
`timescale 1ns/1ps

module poly_eval_tb;
	import poly_mem_pkg::*;
	import poly_eval_pkg::*;

	localparam int n_rows = 8;

	logic clk;
	logic rst;
	logic host_wr;
	logic host_rd;
	mem_addr_t host_addr;
	mem_word_t host_wdata;
	mem_word_t host_rdata;
	logic host_rd_valid;
	logic start;
	poly_sel_t sel;
	point_count_t count;
	data_addr_t base_addr;
	logic done_point;
	logic done_batch;
	result_t result;
	status_t status;

	// testbench copy of the store
	mem_word_t data_m [buffer_size];
	mem_word_t coef_m [coef_depth];
	mem_word_t deg_m [poly_count];

	string row_name [n_rows];
	poly_sel_t row_sel [n_rows];
	point_count_t row_count [n_rows];
	data_addr_t row_base [n_rows];
	bit row_traffic [n_rows];
	bit row_restart [n_rows];

	result_t exp_results [$];
	status_t exp_statuses [$];
	logic [31:0] lfsr_state;
	int timeout_limit;
	int cycles = 0;

	poly_eval_top DUT
	(
		.clk(clk), .rst(rst), .host_wr(host_wr), .host_rd(host_rd),
		.host_addr(host_addr), .host_wdata(host_wdata), .host_rdata(host_rdata),
		.host_rd_valid(host_rd_valid), .start(start), .sel(sel), .count(count),
		.base_addr(base_addr), .done_point(done_point), .done_batch(done_batch),
		.result(result), .status(status)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Checks failed");
		$fatal(1, "stopped at the first error");
	endtask

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= timeout_limit)
			report_failure("timeout: the run took longer than its cycle limit");
	end

	task automatic expect_result(input string name, input result_t exp, input result_t act);
		if (exp !== act)
			report_failure($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic verify_status(input string name, input status_t exp, input status_t act);
		if (exp !== act)
			report_failure($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic compare_word(input string name, input mem_word_t exp, input mem_word_t act);
		if (exp !== act)
			report_failure($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic match_count(input string name, input int exp, input int act);
		if (exp != act)
			report_failure($sformatf("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act));
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	function automatic degree_t used_degree(input poly_sel_t p);
		if (deg_m[p] > 16'd15)
			return 5'd15;
		return degree_t'(deg_m[p]);
	endfunction

	function automatic result_t horner_value(input poly_sel_t p, input mem_word_t x);
		result_t acc;
		acc = '0;
		for (int i = int'(used_degree(p)); i >= 0; i--)
			acc = acc * result_t'(x) + result_t'(coef_m[int'(p) * 16 + i]);
		return acc;
	endfunction

	function automatic status_t expected_status(input data_addr_t a, input poly_sel_t p);
		return {14'b0, used_degree(p), p, a};
	endfunction

	function automatic mem_word_t model_word(input mem_addr_t a);
		if (a < 12'd1024)
			return data_m[a[9:0]];
		if (a < 12'd1152)
			return coef_m[a - 12'd1024];
		if (a < 12'd1160)
			return deg_m[a - 12'd1152];
		return '0;
	endfunction

	function automatic int points_in(input point_count_t c);
		return (c == '0) ? 1 : int'(c);
	endfunction

	task automatic host_write(input mem_addr_t a, input mem_word_t d);
		@(posedge clk);
		host_wr <= 1'b1;
		host_addr <= a;
		host_wdata <= d;
		@(posedge clk);
		host_wr <= 1'b0;
	endtask

	task automatic host_read(input mem_addr_t a, output mem_word_t d);
		int waited;
		waited = 0;
		@(posedge clk);
		host_rd <= 1'b1;
		host_addr <= a;
		@(posedge clk);
		host_rd <= 1'b0;
		do
		begin
			@(negedge clk);
			waited++;
		end
		while (!host_rd_valid && waited < 8);
		if (!host_rd_valid)
			report_failure($sformatf("host read of %h never raised host_rd_valid", a));
		// the host has priority, so its read data always returns two cycles after the strobe
		match_count($sformatf("host read latency %h", a), 2, waited);
		d = host_rdata;
	endtask

	task automatic add_row(input int r, input string name, input poly_sel_t s,
		input point_count_t c, input data_addr_t b, input bit traffic, input bit restart);
		row_name[r] = name;
		row_sel[r] = s;
		row_count[r] = c;
		row_base[r] = b;
		row_traffic[r] = traffic;
		row_restart[r] = restart;
	endtask

	task automatic load_store();
		logic [31:0] bits;
		for (int i = 0; i < buffer_size; i++)
		begin
			take_bits(16, bits);
			data_m[i] = bits[15:0];
			host_write(mem_addr_t'(i), bits[15:0]);
		end
		for (int i = 0; i < coef_depth; i++)
		begin
			take_bits(16, bits);
			coef_m[i] = bits[15:0];
			host_write(12'd1024 + mem_addr_t'(i), bits[15:0]);
		end
		// polynomial 0 is a constant, 7 is full degree and 5 has an oversized degree word
		for (int p = 0; p < poly_count; p++)
		begin
			take_bits(16, bits);
			if (p == 0)
				deg_m[p] = 16'd0;
			else if (p == 7)
				deg_m[p] = 16'd15;
			else if (p == 5)
				deg_m[p] = bits[15:0] | 16'h0010;
			else
				deg_m[p] = {12'b0, bits[3:0]};
			host_write(12'd1152 + mem_addr_t'(p), deg_m[p]);
		end
	endtask

	task automatic read_back();
		mem_addr_t addrs [10];
		mem_word_t got;
		addrs = '{12'd0, 12'd513, 12'd1023, 12'd1024, 12'd1101, 12'd1151,
			12'd1152, 12'd1157, 12'd1159, 12'd2464};
		// unmapped words ignore the write and read as zero
		host_write(12'd2464, 16'hbeef);
		foreach (addrs[i])
		begin
			host_read(addrs[i], got);
			compare_word($sformatf("read back %h", addrs[i]), model_word(addrs[i]), got);
		end
	endtask

	task automatic watch_points(input string name, input int n);
		int seen;
		bit prev_done;
		bit finished;
		seen = 0;
		prev_done = 1'b0;
		finished = 1'b0;
		while (!finished)
		begin
			@(negedge clk);
			if (done_point)
			begin
				if (seen >= n)
					report_failure($sformatf("%s produced more than %0d points", name, n));
				expect_result($sformatf("%s result %0d", name, seen), exp_results[seen], result);
				verify_status($sformatf("%s status %0d", name, seen), exp_statuses[seen], status);
				seen++;
			end
			if (done_batch)
			begin
				if (!prev_done)
					report_failure($sformatf("%s: done_batch did not follow done_point", name));
				match_count($sformatf("%s points", name), n, seen);
				finished = 1'b1;
			end
			prev_done = done_point;
		end
	endtask

	// writes and reads back data words far from the batch points while the batch runs
	task automatic inject_traffic(input string name, input data_addr_t far);
		logic [31:0] bits;
		mem_word_t got;
		data_addr_t a;
		for (int k = 0; k < 10; k++)
		begin
			a = far + data_addr_t'(k);
			take_bits(16, bits);
			data_m[a] = bits[15:0];
			host_write(mem_addr_t'(a), bits[15:0]);
			host_read(mem_addr_t'(a), got);
			compare_word($sformatf("%s host word %0d", name, k), data_m[a], got);
		end
	endtask

	task automatic restart_strobe();
		repeat (5) @(posedge clk);
		start <= 1'b1;
		sel <= 3'd0;
		count <= 5'd9;
		base_addr <= 10'd50;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic run_batch(input int r);
		int n;
		data_addr_t a;
		n = points_in(row_count[r]);
		exp_results.delete();
		exp_statuses.delete();
		for (int i = 0; i < n; i++)
		begin
			a = row_base[r] + data_addr_t'(i);
			exp_results.push_back(horner_value(row_sel[r], data_m[a]));
			exp_statuses.push_back(expected_status(a, row_sel[r]));
		end
		@(posedge clk);
		start <= 1'b1;
		sel <= row_sel[r];
		count <= row_count[r];
		base_addr <= row_base[r];
		@(posedge clk);
		start <= 1'b0;
		fork
			watch_points(row_name[r], n);
			begin
				if (row_traffic[r])
					inject_traffic(row_name[r], row_base[r] + 10'd512);
			end
			begin
				if (row_restart[r])
					restart_strobe();
			end
		join
		if (row_restart[r])
		begin
			repeat (100)
			begin
				@(negedge clk);
				if (done_point || done_batch)
					report_failure("a start strobe during a batch started another batch");
			end
		end
		repeat (3) @(posedge clk);
	endtask

	initial
	begin
		int total_points;
		rst = 1'b0;
		host_wr = 1'b0;
		host_rd = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		start = 1'b0;
		sel = '0;
		count = '0;
		base_addr = '0;
		lfsr_state = 32'habdfe488;
		add_row(0, "count_zero_deg_zero", 3'd0, 5'd0, 10'd10, 1'b0, 1'b0);
		add_row(1, "count_one", 3'd1, 5'd1, 10'd100, 1'b0, 1'b0);
		add_row(2, "full_degree", 3'd7, 5'd4, 10'd200, 1'b0, 1'b0);
		add_row(3, "clipped_degree", 3'd5, 5'd3, 10'd300, 1'b0, 1'b0);
		add_row(4, "wrap_at_buffer_end", 3'd2, 5'd6, 10'd1021, 1'b0, 1'b0);
		add_row(5, "host_traffic", 3'd3, 5'd5, 10'd480, 1'b1, 1'b0);
		add_row(6, "start_ignored", 3'd4, 5'd3, 10'd600, 1'b0, 1'b1);
		add_row(7, "long_batch_traffic", 3'd6, 5'd31, 10'd700, 1'b1, 1'b0);
		total_points = 0;
		for (int r = 0; r < n_rows; r++)
			total_points += points_in(row_count[r]);
		// loading costs about two cycles per word, plus the read back and quiet windows
		timeout_limit = total_points * 200 + (buffer_size + coef_depth + poly_count) * 4 + 1000;

		repeat (4) @(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		verify_status("status after reset", 32'hffff_ffff, status);
		expect_result("result after reset", 32'h0, result);
		if (done_point || done_batch || host_rd_valid)
			report_failure("a done or valid strobe is high right after reset");

		load_store();
		read_back();
		for (int r = 0; r < n_rows; r++)
			run_batch(r);

		$display("All checks passed");
		$finish;
	end

endmodule

//--- build.f
design/poly_mem_pkg.sv
design/poly_eval_pkg.sv
design/store_port_if.sv
design/store_arbiter.sv
design/poly_store.sv
design/host_port.sv
design/poly_point_eval.sv
design/poly_batch_ctrl.sv
design/poly_eval_top.sv
dv/poly_eval_tb.sv
